/* source/db_ctrl_pkg.sv */
package db_ctrl_pkg;

    // ==========================================================
    // Control commands
    // ==========================================================

    // Commands from the controller port
    typedef enum logic [2:0] {
        CMD_NOP   = 3'd0,
        CMD_GET   = 3'd1,
        CMD_SET   = 3'd2,
        CMD_UNSET = 3'd3,
        CMD_CLEAR = 3'd4
    } command_t;

    // ==========================================================
    // Response status
    // ==========================================================

    // Returned with every ack
    typedef enum logic [1:0] {
        STATUS_OK    = 2'd0,
        STATUS_MISS  = 2'd1,
        STATUS_ERROR = 2'd2
    } status_t;

    // ==========================================================
    // Helpers
    // ==========================================================

    // True for any encoding the peripheral knows how to execute
    function automatic logic command_is_valid(input command_t cmd);
        case (cmd)
            CMD_NOP,
            CMD_GET,
            CMD_SET,
            CMD_UNSET,
            CMD_CLEAR: return 1'b1;
            default:   return 1'b0;
        endcase
    endfunction

endpackage

/* source/db_info_pkg.sv */
package db_info_pkg;

    // ==========================================================
    // Database identity
    // ==========================================================

    // Kind of database behind the control port
    typedef enum logic [7:0] {
        DB_TYPE_UNSPECIFIED = 8'd0,
        DB_TYPE_STATE       = 8'd1,
        DB_TYPE_MAP         = 8'd2
    } type_t;

    // Implementation specific, meaning depends on type_t
    typedef logic [7:0] subtype_t;

endpackage

/* source/db_ctrl_connector.sv */
module db_ctrl_connector #(
    parameter type KEY_T   = logic [7:0],
    parameter type VALUE_T = logic [31:0]
) (
    input  logic                  clk,
    input  logic                  rst_n,
    // Controller side
    input  logic                  up_req,
    input  db_ctrl_pkg::command_t up_command,
    input  KEY_T                  up_key,
    input  VALUE_T                up_set_value,
    output logic                  up_rdy,
    output logic                  up_ack,
    output db_ctrl_pkg::status_t  up_status,
    output logic                  up_get_valid,
    output VALUE_T                up_get_value,
    // Peripheral side
    output logic                  dn_req,
    output db_ctrl_pkg::command_t dn_command,
    output KEY_T                  dn_key,
    output VALUE_T                dn_set_value,
    input  logic                  dn_rdy,
    input  logic                  dn_ack,
    input  db_ctrl_pkg::status_t  dn_status,
    input  logic                  dn_get_valid,
    input  VALUE_T                dn_get_value
);

    logic accept;
    // Accepted, ack not yet returned upstream
    logic outstanding;
    // Request issued to peripheral, ack not yet seen there
    logic dn_busy;

    assign accept = up_req && up_rdy;
    // Hold off until the registered ack has gone out
    assign up_rdy = dn_rdy && !outstanding;

    // ==========================================================
    // Control registers
    // ==========================================================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dn_req      <= 1'b0;
            up_ack      <= 1'b0;
            outstanding <= 1'b0;
            dn_busy     <= 1'b0;
        end else begin
            // One-cycle strobe towards the peripheral
            dn_req <= accept;
            up_ack <= dn_ack;
            if (accept) begin
                outstanding <= 1'b1;
            end else if (up_ack) begin
                outstanding <= 1'b0;
            end
            if (dn_req) begin
                dn_busy <= 1'b1;
            end else if (dn_ack) begin
                dn_busy <= 1'b0;
            end
        end
    end

    // ==========================================================
    // Payload registers
    // ==========================================================
    always_ff @(posedge clk) begin
        // Request fields stay put until the next acceptance
        if (accept) begin
            dn_command   <= up_command;
            dn_key       <= up_key;
            dn_set_value <= up_set_value;
        end
        // Response fields, meaningful only alongside up_ack
        up_status    <= dn_status;
        up_get_valid <= dn_get_valid;
        up_get_value <= dn_get_value;
    end

    // Peripheral must be idle and free when a new request goes down
    assert property (@(posedge clk) disable iff (!rst_n)
        dn_req |-> (dn_rdy && !dn_busy));

endmodule

/* source/db_peripheral.sv */
module db_peripheral #(
    parameter type KEY_T   = logic [7:0],
    parameter type VALUE_T = logic [31:0]
) (
    input  logic                  clk,
    input  logic                  rst_n,
    // Control side
    input  logic                  req,
    input  db_ctrl_pkg::command_t command,
    input  KEY_T                  key,
    input  VALUE_T                set_value,
    output logic                  rdy,
    output logic                  ack,
    output db_ctrl_pkg::status_t  status,
    output logic                  get_valid,
    output VALUE_T                get_value,
    // Store clearing
    output logic                  init,
    input  logic                  init_done,
    // Store write port
    output logic                  wr,
    output KEY_T                  wr_key,
    output VALUE_T                wr_value,
    output logic                  wr_valid,
    // Store read port
    output logic                  rd_req,
    output KEY_T                  rd_key,
    input  logic                  rd_ack,
    input  logic                  rd_valid,
    input  VALUE_T                rd_value
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_READ,
        ST_READ_WAIT,
        ST_WRITE,
        ST_ACK,
        ST_CLEARING
    } state_t;

    state_t                state;
    logic                  accept;
    // Latched request
    db_ctrl_pkg::command_t cmd_r;
    KEY_T                  key_r;
    VALUE_T                value_r;
    // Latched result
    db_ctrl_pkg::status_t  status_r;
    logic                  get_valid_r;
    VALUE_T                get_value_r;

    assign rdy    = (state == ST_IDLE) && init_done;
    assign accept = req && rdy;

    // ==========================================================
    // Sequencer FSM
    // ==========================================================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= ST_IDLE;
            init  <= 1'b0;
        end else begin
            init <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (accept) begin
                        case (command)
                            db_ctrl_pkg::CMD_GET,
                            db_ctrl_pkg::CMD_UNSET: state <= ST_READ;
                            db_ctrl_pkg::CMD_SET:   state <= ST_WRITE;
                            db_ctrl_pkg::CMD_CLEAR: begin
                                state <= ST_CLEARING;
                                init  <= 1'b1;
                            end
                            // NOP and unknown encodings ack at once
                            default: state <= ST_ACK;
                        endcase
                    end
                end
                ST_READ: state <= ST_READ_WAIT;
                ST_READ_WAIT: begin
                    if (rd_ack) begin
                        // UNSET always writes back, even for an absent key
                        state <= (cmd_r == db_ctrl_pkg::CMD_UNSET) ? ST_WRITE : ST_ACK;
                    end
                end
                ST_WRITE: state <= ST_ACK;
                ST_ACK:   state <= ST_IDLE;
                ST_CLEARING: begin
                    // init_done still high in the init cycle itself
                    if (init_done && !init) begin
                        state <= ST_ACK;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // ==========================================================
    // Request and result registers
    // ==========================================================
    always_ff @(posedge clk) begin
        if (accept) begin
            cmd_r       <= command;
            key_r       <= key;
            value_r     <= set_value;
            status_r    <= db_ctrl_pkg::command_is_valid(command) ?
                           db_ctrl_pkg::STATUS_OK : db_ctrl_pkg::STATUS_ERROR;
            get_valid_r <= 1'b0;
            get_value_r <= '0;
        end else if ((state == ST_READ_WAIT) && rd_ack) begin
            if (!rd_valid) begin
                status_r <= db_ctrl_pkg::STATUS_MISS;
            end else if (cmd_r == db_ctrl_pkg::CMD_GET) begin
                get_valid_r <= 1'b1;
                get_value_r <= rd_value;
            end
        end
    end

    // Store accesses
    assign rd_req   = (state == ST_READ);
    assign rd_key   = key_r;
    assign wr       = (state == ST_WRITE);
    assign wr_key   = key_r;
    assign wr_value = value_r;
    // SET marks valid, UNSET clears
    assign wr_valid = (cmd_r == db_ctrl_pkg::CMD_SET);

    // Response
    assign ack       = (state == ST_ACK);
    assign status    = status_r;
    assign get_valid = get_valid_r;
    assign get_value = get_value_r;

    // Store answers only what was asked, one cycle later
    assert property (@(posedge clk) disable iff (!rst_n) rd_ack |-> $past(rd_req));

endmodule

/* source/db_store_array.sv */
module db_store_array #(
    parameter type KEY_T   = logic [7:0],
    parameter type VALUE_T = logic [31:0]
) (
    input  logic   clk,
    input  logic   rst_n,
    // Clearing
    input  logic   init,
    output logic   init_done,
    // Write port
    input  logic   wr,
    input  KEY_T   wr_key,
    input  VALUE_T wr_value,
    input  logic   wr_valid,
    // Read port
    input  logic   rd_req,
    input  KEY_T   rd_key,
    output logic   rd_ack,
    output logic   rd_valid,
    output VALUE_T rd_value
);

    localparam int KEY_W = $bits(KEY_T);
    // One entry per possible key
    localparam int DEPTH = 2 ** KEY_W;

    VALUE_T             value_mem [DEPTH];
    logic               valid_mem [DEPTH];
    // Sweep position
    logic [KEY_W-1:0]   sweep_cnt;

    // ==========================================================
    // Clearing sweep
    // ==========================================================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            // Reset starts a sweep on its own
            init_done <= 1'b0;
            sweep_cnt <= '0;
        end else if (init) begin
            init_done <= 1'b0;
            sweep_cnt <= '0;
        end else if (!init_done) begin
            sweep_cnt <= sweep_cnt + 1'b1;
            // Last entry cleared this cycle
            if (&sweep_cnt) begin
                init_done <= 1'b1;
            end
        end
    end

    // ==========================================================
    // Storage
    // ==========================================================
    always_ff @(posedge clk) begin
        if (!init_done) begin
            valid_mem[sweep_cnt] <= 1'b0;
        end else if (wr) begin
            valid_mem[wr_key] <= wr_valid;
        end
    end

    // Values need no clearing, valid bit gates them
    always_ff @(posedge clk) begin
        if (wr) begin
            value_mem[wr_key] <= wr_value;
        end
    end

    // Read answer, fixed one-cycle latency
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_ack <= 1'b0;
        end else begin
            rd_ack <= rd_req;
        end
    end

    always_ff @(posedge clk) begin
        rd_valid <= valid_mem[rd_key];
        rd_value <= value_mem[rd_key];
    end

    // Peripheral keeps off the store during a sweep
    assert property (@(posedge clk) disable iff (!rst_n) !init_done |-> !(wr || rd_req));

endmodule

/* source/db_subsystem.sv */
module db_subsystem #(
    parameter type                   KEY_T      = logic [7:0],
    parameter type                   VALUE_T    = logic [31:0],
    parameter db_info_pkg::type_t    DB_TYPE    = db_info_pkg::DB_TYPE_UNSPECIFIED,
    parameter db_info_pkg::subtype_t DB_SUBTYPE = 8'h00
) (
    input  logic                  clk,
    input  logic                  rst_n,
    // Controller port
    input  logic                  req,
    input  db_ctrl_pkg::command_t command,
    input  KEY_T                  key,
    input  VALUE_T                set_value,
    output logic                  rdy,
    output logic                  ack,
    output db_ctrl_pkg::status_t  status,
    output logic                  get_valid,
    output VALUE_T                get_value,
    // Identity
    output db_info_pkg::type_t    info_type,
    output db_info_pkg::subtype_t info_subtype,
    output logic [31:0]           info_size
);

    // ==========================================================
    // Internal wiring
    // ==========================================================

    // Connector to peripheral
    logic                  p_req;
    db_ctrl_pkg::command_t p_command;
    KEY_T                  p_key;
    VALUE_T                p_set_value;
    logic                  p_rdy;
    logic                  p_ack;
    db_ctrl_pkg::status_t  p_status;
    logic                  p_get_valid;
    VALUE_T                p_get_value;

    // Peripheral to store
    logic   init;
    logic   init_done;
    logic   wr;
    KEY_T   wr_key;
    VALUE_T wr_value;
    logic   wr_valid;
    logic   rd_req;
    KEY_T   rd_key;
    logic   rd_ack;
    logic   rd_valid;
    VALUE_T rd_value;

    // Fixed identity
    assign info_type    = DB_TYPE;
    assign info_subtype = DB_SUBTYPE;
    assign info_size    = 32'(2 ** $bits(KEY_T));

    // ==========================================================
    // Instances
    // ==========================================================
    db_ctrl_connector #(
        .KEY_T   (KEY_T),
        .VALUE_T (VALUE_T)
    ) i_db_ctrl_connector (
        .clk          (clk),
        .rst_n        (rst_n),
        .up_req       (req),
        .up_command   (command),
        .up_key       (key),
        .up_set_value (set_value),
        .up_rdy       (rdy),
        .up_ack       (ack),
        .up_status    (status),
        .up_get_valid (get_valid),
        .up_get_value (get_value),
        .dn_req       (p_req),
        .dn_command   (p_command),
        .dn_key       (p_key),
        .dn_set_value (p_set_value),
        .dn_rdy       (p_rdy),
        .dn_ack       (p_ack),
        .dn_status    (p_status),
        .dn_get_valid (p_get_valid),
        .dn_get_value (p_get_value)
    );

    db_peripheral #(
        .KEY_T   (KEY_T),
        .VALUE_T (VALUE_T)
    ) i_db_peripheral (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (p_req),
        .command   (p_command),
        .key       (p_key),
        .set_value (p_set_value),
        .rdy       (p_rdy),
        .ack       (p_ack),
        .status    (p_status),
        .get_valid (p_get_valid),
        .get_value (p_get_value),
        .init      (init),
        .init_done (init_done),
        .wr        (wr),
        .wr_key    (wr_key),
        .wr_value  (wr_value),
        .wr_valid  (wr_valid),
        .rd_req    (rd_req),
        .rd_key    (rd_key),
        .rd_ack    (rd_ack),
        .rd_valid  (rd_valid),
        .rd_value  (rd_value)
    );

    db_store_array #(
        .KEY_T   (KEY_T),
        .VALUE_T (VALUE_T)
    ) i_db_store_array (
        .clk       (clk),
        .rst_n     (rst_n),
        .init      (init),
        .init_done (init_done),
        .wr        (wr),
        .wr_key    (wr_key),
        .wr_value  (wr_value),
        .wr_valid  (wr_valid),
        .rd_req    (rd_req),
        .rd_key    (rd_key),
        .rd_ack    (rd_ack),
        .rd_valid  (rd_valid),
        .rd_value  (rd_value)
    );

endmodule

/* test/tb_db_subsystem.sv */
module tb_db_subsystem;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int KEY_W       = 8;
    localparam int VALUE_W     = 32;
    localparam int STORE_SIZE  = 2 ** KEY_W;
    // SET and GET latencies at the top level, in cycles after acceptance
    localparam int SET_LATENCY = 4;
    localparam int GET_LATENCY = 5;
    localparam int MAX_LATENCY = 8;
    // ~400 commands at up to 8 cycles, 3 sweeps of ~300 cycles, plus margin
    localparam int CYCLE_LIMIT = 12000;

    logic                  clk;
    logic                  rst_n;
    logic                  req;
    db_ctrl_pkg::command_t command;
    logic [KEY_W-1:0]      key;
    logic [VALUE_W-1:0]    set_value;
    logic                  rdy;
    logic                  ack;
    db_ctrl_pkg::status_t  status;
    logic                  get_valid;
    logic [VALUE_W-1:0]    get_value;
    db_info_pkg::type_t    info_type;
    db_info_pkg::subtype_t info_subtype;
    logic [31:0]           info_size;

    // Reference model, key to value
    logic [VALUE_W-1:0]    model [logic [KEY_W-1:0]];

    // Scoreboard state
    int                    issued       = 0;
    int                    acked        = 0;
    int                    stall_cycles = 0;
    int                    cycles       = 0;
    int                    latency      = 0;
    bit                    in_flight    = 1'b0;
    db_ctrl_pkg::command_t pend_cmd;
    logic [KEY_W-1:0]      pend_key;
    logic [VALUE_W-1:0]    pend_value;

    db_subsystem #(
        .KEY_T      (logic [KEY_W-1:0]),
        .VALUE_T    (logic [VALUE_W-1:0]),
        .DB_TYPE    (db_info_pkg::DB_TYPE_MAP),
        .DB_SUBTYPE (8'hDB)
    ) dut0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .req          (req),
        .command      (command),
        .key          (key),
        .set_value    (set_value),
        .rdy          (rdy),
        .ack          (ack),
        .status       (status),
        .get_valid    (get_valid),
        .get_value    (get_value),
        .info_type    (info_type),
        .info_subtype (info_subtype),
        .info_size    (info_size)
    );

    // ============================================================
    // Clock and cycle limit
    // ============================================================
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Run hung: commands still pending after %0d cycles", CYCLE_LIMIT);
            $display("Verification failed");
            $fatal(1, "cycle limit reached");
        end
    end

    // ============================================================
    // Checking
    // ============================================================
    task automatic check_equal(input logic [63:0] actual, input logic [63:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("[FAIL] %0t: %s (got %0h, expected %0h)", $time, what, actual, expected);
            $display("Verification failed");
            $fatal(1, "mismatch");
        end
    endtask

    // Expected response worked out from the model, model updated after
    task automatic score_response(input db_ctrl_pkg::command_t cmd, input logic [KEY_W-1:0] k,
                                  input logic [VALUE_W-1:0] v, input int lat);
        db_ctrl_pkg::status_t exp_status;
        logic                 exp_valid;
        logic [VALUE_W-1:0]   exp_value;
        exp_status = db_ctrl_pkg::STATUS_OK;
        exp_valid  = 1'b0;
        exp_value  = '0;
        case (cmd)
            db_ctrl_pkg::CMD_SET: begin
                model[k] = v;
                check_equal(lat, SET_LATENCY, "SET ack latency");
            end
            db_ctrl_pkg::CMD_GET: begin
                if (model.exists(k)) begin
                    exp_valid = 1'b1;
                    exp_value = model[k];
                end else begin
                    exp_status = db_ctrl_pkg::STATUS_MISS;
                end
                check_equal(lat, GET_LATENCY, "GET ack latency");
            end
            db_ctrl_pkg::CMD_UNSET: begin
                if (model.exists(k)) begin
                    model.delete(k);
                end else begin
                    exp_status = db_ctrl_pkg::STATUS_MISS;
                end
                check_equal(lat <= MAX_LATENCY, 1'b1, "UNSET ack latency bound");
            end
            db_ctrl_pkg::CMD_CLEAR: begin
                model.delete();
                // Sweep covers every entry before the ack
                check_equal(lat >= STORE_SIZE, 1'b1, "CLEAR acked before sweep end");
            end
            default: begin
            end
        endcase
        check_equal(status, exp_status, $sformatf("%s status, key %0h", cmd.name(), k));
        check_equal(get_valid, exp_valid, $sformatf("%s get_valid, key %0h", cmd.name(), k));
        if (exp_valid) begin
            check_equal(get_value, exp_value, $sformatf("GET value, key %0h", k));
        end
    endtask

    // Handshake monitor, sampled on the rising edge before any update
    always @(posedge clk) begin
        if (rst_n) begin
            if (in_flight) begin
                latency++;
                check_equal(rdy, 1'b0, "rdy high while a command is outstanding");
                if (ack) begin
                    score_response(pend_cmd, pend_key, pend_value, latency);
                    in_flight = 1'b0;
                    acked++;
                end
            end else begin
                check_equal(ack, 1'b0, "ack with no command outstanding");
            end
            if (req && !rdy) begin
                stall_cycles++;
            end
            // Acceptance
            if (req && rdy) begin
                in_flight  = 1'b1;
                latency    = 0;
                pend_cmd   = command;
                pend_key   = key;
                pend_value = set_value;
            end
        end
    end

    // ============================================================
    // Stimulus
    // ============================================================
    function automatic db_ctrl_pkg::command_t choose_command(input bit allow_unset,
                                                             input bit allow_clear);
        int unsigned roll;
        roll = $urandom_range(99, 0);
        if (allow_clear && roll < 2) begin
            return db_ctrl_pkg::CMD_CLEAR;
        end
        if (allow_unset && roll < 30) begin
            return db_ctrl_pkg::CMD_UNSET;
        end
        return (roll < 65) ? db_ctrl_pkg::CMD_SET : db_ctrl_pkg::CMD_GET;
    endfunction

    // Holds the request until accepted, then an idle gap of 0 to max_gap
    // A zero gap leaves req high for the next command
    task automatic send_command(input db_ctrl_pkg::command_t cmd, input logic [KEY_W-1:0] k,
                                input logic [VALUE_W-1:0] v, input int max_gap);
        int gap;
        req       <= 1'b1;
        command   <= cmd;
        key       <= k;
        set_value <= v;
        do begin
            @(posedge clk);
        end while (!rdy);
        issued++;
        gap = $urandom_range(max_gap, 0);
        if (gap > 0) begin
            req <= 1'b0;
            repeat (gap) @(posedge clk);
        end
    endtask

    // Drop req and wait until rdy returns, nothing left in the DUT
    task automatic wait_idle();
        req <= 1'b0;
        do begin
            @(posedge clk);
        end while (!rdy);
    endtask

    initial begin
        logic [KEY_W-1:0]      old_keys [$];
        logic [KEY_W-1:0]      k;
        db_ctrl_pkg::command_t cmd;
        void'($urandom(70));
        rst_n     = 1'b0;
        req       = 1'b0;
        command   = db_ctrl_pkg::CMD_NOP;
        key       = '0;
        set_value = '0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;

        // Reset sweep first, rdy follows
        do begin
            @(posedge clk);
        end while (!rdy);
        check_equal(info_type, db_info_pkg::DB_TYPE_MAP, "info_type");
        check_equal(info_subtype, 8'hDB, "info_subtype");
        check_equal(info_size, STORE_SIZE, "info_size");

        // Empty store misses everywhere
        for (int i = 0; i < 16; i++) begin
            send_command(db_ctrl_pkg::CMD_GET, 8'($urandom_range(255, 0)), '0, 3);
        end

        // SET and GET on 16 keys so hits are common
        for (int i = 0; i < 200; i++) begin
            cmd = choose_command(1'b0, 1'b0);
            send_command(cmd, 8'($urandom_range(15, 0)), $urandom(), 3);
        end

        // UNSET mix, each UNSET followed by a GET of the same key
        for (int i = 0; i < 60; i++) begin
            cmd = choose_command(1'b1, 1'b0);
            k   = 8'($urandom_range(15, 0));
            send_command(cmd, k, $urandom(), 3);
            if (cmd == db_ctrl_pkg::CMD_UNSET) begin
                send_command(db_ctrl_pkg::CMD_GET, k, '0, 3);
            end
        end
        wait_idle();

        // ============================================================
        // CLEAR, then every key set before it
        // ============================================================
        foreach (model[idx]) begin
            old_keys.push_back(idx);
        end
        check_equal(old_keys.size() > 0, 1'b1, "no keys set before CLEAR");
        send_command(db_ctrl_pkg::CMD_CLEAR, '0, '0, 0);
        foreach (old_keys[i]) begin
            send_command(db_ctrl_pkg::CMD_GET, old_keys[i], '0, 1);
        end
        wait_idle();

        // Back-pressure: req held with random short gaps, rare CLEAR
        for (int i = 0; i < 100; i++) begin
            cmd = choose_command(1'b1, 1'b1);
            send_command(cmd, 8'($urandom_range(15, 0)), $urandom(), 2);
        end
        wait_idle();

        check_equal(acked, issued, "ack count against requests issued");
        check_equal(stall_cycles > 0, 1'b1, "no request ever held against low rdy");
        $display("Verification passed");
        $finish;
    end

endmodule

/* vlog.f */
source/db_ctrl_pkg.sv
source/db_info_pkg.sv
source/db_ctrl_connector.sv
source/db_peripheral.sv
source/db_store_array.sv
source/db_subsystem.sv
test/tb_db_subsystem.sv

/* run_sim.sh */
#!/bin/sh
# Build with Verilator, run, and look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --assert -Wno-fatal -f vlog.f --top-module tb_db_subsystem \
    > build.log 2>&1 \
    && ./obj_dir/Vtb_db_subsystem > sim.log 2>&1 ; cat sim.log
grep -q "Verification passed" sim.log && echo "Simulation PASSED" \
    || { echo "Simulation FAILED (see build.log and sim.log)"; exit 1; }
